// File: common/debug_print_settings.svh
`ifndef DEBUG_PRINT_SETTINGS_SVH
`define DEBUG_PRINT_SETTINGS_SVH

// Width of the value that a capture samples
// 30 leaves a two-bit top nibble, which gets zero-padded
`define DBG_VALUE_BITS 30

// Clock cycles per serial bit on txd
// Also shared with the receiver model in the testbench
`define UART_CLKS_PER_BIT 8

// Line ending sent after the last hex digit
`define DBG_LINE_CR 8'h0D
`define DBG_LINE_LF 8'h0A

`endif

// File: common/debug_print_pkg.sv
`default_nettype none

`include "debug_print_settings.svh"

package debug_print_pkg;

  // Hex digits needed to hold the value, rounded up to whole nibbles
  localparam int N_NIBBLES = (`DBG_VALUE_BITS + 3) / 4;

  // One ASCII character
  typedef logic [7:0] ascii_t;

  // Raw captured value
  typedef logic [`DBG_VALUE_BITS-1:0] value_t;

  // Printed line without its ending, index 0 holds the least significant digit
  typedef ascii_t [N_NIBBLES-1:0] hex_line_t;

  // Print request from outside, capture is a one-cycle strobe
  typedef struct packed {
    logic   capture;
    value_t value;
  } print_req_t;

  // Formatter FSM
  typedef enum logic [1:0] {
    FMT_IDLE,
    FMT_LATCH,
    FMT_SEND,
    FMT_WAIT
  } fmt_state_e;

endpackage

`default_nettype wire

// File: common/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // Character handed to the transmitter
  // load is a one-cycle strobe, data is only looked at while load is high
  typedef struct packed {
    logic       load;
    logic [7:0] data;
  } tx_char_t;

  // Transmitter FSM, one state per frame phase
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_state_e;

endpackage

`default_nettype wire

// File: source/bits_to_hex.sv
`default_nettype none

module bits_to_hex
  import debug_print_pkg::*;
#(
  parameter int N_BITS = 32
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [N_BITS-1:0]                bits,
  output ascii_t [(N_BITS + 3) / 4 - 1:0]  ascii
);

  // Ceiling of N_BITS / 4
  localparam int N_DIGITS = (N_BITS + 3) / 4;

  // Value widened to whole nibbles
  logic [4*N_DIGITS-1:0] padded;

  // One nibble to "0".."9" or "A".."F"
  function automatic ascii_t nibble_to_ascii(input logic [3:0] nibble);
    if (nibble < 4'd10) begin
      return ascii_t'("0") + ascii_t'(nibble);
    end
    return ascii_t'("A") + ascii_t'(nibble - 4'd10);
  endfunction

  // Upper bits of a partial top nibble read as zero
  always_comb begin
    padded = '0;
    padded[N_BITS-1:0] = bits;
  end

  // Converted every cycle whether or not anyone captures
  always_ff @(posedge clk) begin
    if (reset) begin
      ascii <= '0;
    end else begin
      for (int i = 0; i < N_DIGITS; i++) begin
        ascii[i] <= nibble_to_ascii(padded[4*i +: 4]);
      end
    end
  end

endmodule

`default_nettype wire

// File: source/hex_line_formatter.sv
`default_nettype none

`include "debug_print_settings.svh"

module hex_line_formatter
  import debug_print_pkg::*;
  import uart_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      capture,
  input  hex_line_t ascii,
  input  logic      tx_busy,
  output tx_char_t  tx_char,
  output logic      busy
);

  // Digits plus CR and LF
  localparam int N_CHARS = N_NIBBLES + 2;
  localparam int IDX_W   = $clog2(N_CHARS);

  fmt_state_e       state_q;

  // Copy of the converter output, held for the whole line
  hex_line_t        line_q;

  // Characters still to send after the current one
  // N_CHARS-1 is the top digit, 1 is CR, 0 is LF
  logic [IDX_W-1:0] char_idx_q;

  logic             last_char;
  ascii_t           tx_byte;

  assign last_char = (char_idx_q == '0);

  // FSM
  // IDLE  waits for a capture, anything arriving later is dropped
  // LATCH takes the converted text, one cycle after the value
  // SEND  pulses the load for one character
  // WAIT  holds until the transmitter frees up again
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= FMT_IDLE;
      char_idx_q <= '0;
    end else begin
      case (state_q)
        FMT_IDLE: begin
          if (capture) begin
            state_q <= FMT_LATCH;
          end
        end
        FMT_LATCH: begin
          state_q    <= FMT_SEND;
          char_idx_q <= IDX_W'(N_CHARS - 1);
        end
        FMT_SEND: begin
          // tx_busy only rises next cycle, so never look at it here
          state_q <= FMT_WAIT;
        end
        FMT_WAIT: begin
          if (!tx_busy) begin
            if (last_char) begin
              state_q <= FMT_IDLE;
            end else begin
              state_q    <= FMT_SEND;
              char_idx_q <= char_idx_q - 1'b1;
            end
          end
        end
        default: begin
          state_q <= FMT_IDLE;
        end
      endcase
    end
  end

  // Line store
  always_ff @(posedge clk) begin
    if (state_q == FMT_LATCH) begin
      line_q <= ascii;
    end
  end

  // Character select, top digit first then the line ending
  always_comb begin
    if (char_idx_q == IDX_W'(1)) begin
      tx_byte = `DBG_LINE_CR;
    end else if (last_char) begin
      tx_byte = `DBG_LINE_LF;
    end else begin
      tx_byte = line_q[char_idx_q - IDX_W'(2)];
    end
  end

  // Exactly one load per SEND visit
  always_comb begin
    tx_char.load = (state_q == FMT_SEND);
    tx_char.data = tx_byte;
  end

  // High from the latch cycle until the LF has left the transmitter
  assign busy = (state_q != FMT_IDLE);

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
`default_nettype none

`include "debug_print_settings.svh"

module uart_tx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic     clk,
  input  logic     reset,
  input  tx_char_t tx_char,
  output logic     txd,
  output logic     tx_busy
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  uart_state_e      state_q;
  uart_state_e      state_d;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [CNT_W-1:0] clk_cnt_d;
  logic [2:0]       bit_cnt_q;
  logic [2:0]       bit_cnt_d;
  logic [7:0]       shift_q;
  logic [7:0]       shift_d;
  logic             txd_d;
  logic             bit_done;

  // Last cycle of the current bit period
  assign bit_done = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  // Next-state logic
  always_comb begin
    state_d   = state_q;
    clk_cnt_d = bit_done ? '0 : clk_cnt_q + 1'b1;
    bit_cnt_d = bit_cnt_q;
    shift_d   = shift_q;
    case (state_q)
      TX_IDLE: begin
        // Period counter parked so the start bit gets a full period
        clk_cnt_d = '0;
        bit_cnt_d = '0;
        // No busy check here, the sender guards the load timing
        if (tx_char.load) begin
          state_d = TX_START;
          shift_d = tx_char.data;
        end
      end
      TX_START: begin
        if (bit_done) begin
          state_d = TX_DATA;
        end
      end
      TX_DATA: begin
        if (bit_done) begin
          // LSB first
          shift_d   = {1'b0, shift_q[7:1]};
          bit_cnt_d = bit_cnt_q + 1'b1;
          if (bit_cnt_q == 3'd7) begin
            state_d = TX_STOP;
          end
        end
      end
      TX_STOP: begin
        if (bit_done) begin
          state_d = TX_IDLE;
        end
      end
      default: begin
        state_d = TX_IDLE;
      end
    endcase
  end

  // Line level follows the next state so txd comes straight from a flop
  always_comb begin
    case (state_d)
      TX_START: txd_d = 1'b0;
      TX_DATA:  txd_d = shift_d[0];
      default:  txd_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      txd       <= 1'b1;
    end else begin
      state_q   <= state_d;
      clk_cnt_q <= clk_cnt_d;
      bit_cnt_q <= bit_cnt_d;
      txd       <= txd_d;
    end
  end

  // Data byte
  always_ff @(posedge clk) begin
    shift_q <= shift_d;
  end

  // Low again only once the stop bit has gone out in full
  assign tx_busy = (state_q != TX_IDLE);

endmodule

`default_nettype wire

// File: source/debug_hex_printer.sv
`default_nettype none

`include "debug_print_settings.svh"

module debug_hex_printer
  import debug_print_pkg::*;
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  print_req_t req,
  output logic       txd,
  output logic       busy
);

  // Converter text, valid one cycle after the value
  hex_line_t ascii;

  // Formatter to transmitter
  tx_char_t  tx_char;
  logic      tx_busy;

  // Runs freely on every value, the formatter picks which one it keeps
  bits_to_hex #(
    .N_BITS(`DBG_VALUE_BITS)
  ) u_bits_to_hex (
    .clk  (clk),
    .reset(reset),
    .bits (req.value),
    .ascii(ascii)
  );

  // Captures while busy are dropped in here
  hex_line_formatter u_hex_line_formatter (
    .clk    (clk),
    .reset  (reset),
    .capture(req.capture),
    .ascii  (ascii),
    .tx_busy(tx_busy),
    .tx_char(tx_char),
    .busy   (busy)
  );

  // 8N1 at the default divisor
  uart_tx u_uart_tx (
    .clk    (clk),
    .reset  (reset),
    .tx_char(tx_char),
    .txd    (txd),
    .tx_busy(tx_busy)
  );

endmodule

`default_nettype wire

// File: tests/uart_rx_model.sv
`default_nettype none

`include "debug_print_settings.svh"

module uart_rx_model
  import debug_print_pkg::*;
#(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   txd,
  output logic   byte_valid,
  output ascii_t byte_data,
  output logic   framing_error
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e state;

  // Cycles since the last sample point
  int        clk_cnt;
  int        bit_idx;
  ascii_t    shift;

  // Start edge seen one cycle late, so mid-bit sits CLKS_PER_BIT/2 - 1 counts later
  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= RX_IDLE;
      clk_cnt       <= 0;
      bit_idx       <= 0;
      shift         <= '0;
      byte_valid    <= 1'b0;
      byte_data     <= '0;
      framing_error <= 1'b0;
    end else begin
      byte_valid    <= 1'b0;
      framing_error <= 1'b0;
      clk_cnt       <= clk_cnt + 1;
      case (state)
        RX_IDLE: begin
          clk_cnt <= 0;
          if (!txd) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt == CLKS_PER_BIT / 2 - 1) begin
            clk_cnt <= 0;
            bit_idx <= 0;
            // Line back high at mid start bit means a glitch
            if (txd) begin
              state <= RX_IDLE;
            end else begin
              state <= RX_DATA;
            end
          end
        end
        RX_DATA: begin
          if (clk_cnt == CLKS_PER_BIT - 1) begin
            clk_cnt <= 0;
            // LSB arrives first
            shift   <= {txd, shift[7:1]};
            bit_idx <= bit_idx + 1;
            if (bit_idx == 7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (clk_cnt == CLKS_PER_BIT - 1) begin
            state <= RX_IDLE;
            if (txd) begin
              byte_valid <= 1'b1;
              byte_data  <= shift;
            end else begin
              framing_error <= 1'b1;
              $display("uart_rx_model: stop bit was low, framing error");
            end
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_debug_hex_printer.sv
`default_nettype none

`include "debug_print_settings.svh"

module tb_debug_hex_printer
  import debug_print_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_CHARS        = N_NIBBLES + 2;
  // One char is 10 bit times plus a short gap
  localparam int LINE_CYCLES    = N_CHARS * (10 * `UART_CLKS_PER_BIT + 2);
  localparam int N_LINES        = 22;
  localparam int TIMEOUT_CYCLES = (N_LINES + 8) * LINE_CYCLES;

  // Index N_CHARS-1 goes out first
  typedef ascii_t [N_CHARS-1:0] line_bytes_t;

  logic       clk;
  logic       reset;
  print_req_t req;
  logic       txd;
  logic       busy;
  logic       rx_valid;
  ascii_t     rx_data;
  logic       framing_error;

  ascii_t     exp_q[$];
  string      test_name = "reset";
  int         seed = 23;
  int         cycle_count = 0;
  int         rx_count = 0;

  debug_hex_printer u_dut (
    .clk  (clk),
    .reset(reset),
    .req  (req),
    .txd  (txd),
    .busy (busy)
  );

  uart_rx_model u_rx (
    .clk          (clk),
    .reset        (reset),
    .txd          (txd),
    .byte_valid   (rx_valid),
    .byte_data    (rx_data),
    .framing_error(framing_error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at first error");
  endtask

  // Expected text, uppercase hex with the top nibble zero-padded, then CR LF
  function automatic line_bytes_t expected_line(input value_t value);
    string                  hex_digits;
    logic [4*N_NIBBLES-1:0] padded;
    line_bytes_t            chars;
    hex_digits = "0123456789ABCDEF";
    padded = '0;
    padded[`DBG_VALUE_BITS-1:0] = value;
    for (int i = 0; i < N_NIBBLES; i++) begin
      chars[N_CHARS-1-i] = hex_digits[padded[4*(N_NIBBLES-1-i) +: 4]];
    end
    chars[1] = `DBG_LINE_CR;
    chars[0] = `DBG_LINE_LF;
    return chars;
  endfunction

  // Capture taken by the DUT when it is idle, queue its line
  always @(negedge clk) begin
    line_bytes_t chars;
    if (!reset && req.capture && !busy) begin
      chars = expected_line(req.value);
      for (int i = N_CHARS - 1; i >= 0; i--) begin
        exp_q.push_back(chars[i]);
      end
    end
  end

  // Compare every received byte against the head of the queue
  always @(posedge clk) begin
    ascii_t expected;
    if (!reset && rx_valid) begin
      rx_count <= rx_count + 1;
      assert (exp_q.size() > 0) else
        abort_run($sformatf("%s: byte 8'h%02h arrived with no line pending", test_name, rx_data));
      if (exp_q.size() > 0) begin
        expected = exp_q.pop_front();
        assert (rx_data == expected) else
          abort_run($sformatf("[FAIL] %s: expected 8'h%02h actual 8'h%02h",
                              test_name, expected, rx_data));
      end
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      assert (!framing_error) else
        abort_run($sformatf("%s: stop bit on txd was low", test_name));
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    assert (cycle_count < TIMEOUT_CYCLES) else
      abort_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress",
                          cycle_count));
  end

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic capture_value(input value_t value);
    @(posedge clk);
    req.capture <= 1'b1;
    req.value   <= value;
    @(posedge clk);
    req.capture <= 1'b0;
  endtask

  task automatic wait_busy_high();
    @(negedge clk);
    while (!busy) @(negedge clk);
  endtask

  task automatic wait_busy_low();
    while (busy) @(negedge clk);
  endtask

  task automatic print_line(input value_t value);
    capture_value(value);
    wait_busy_high();
    wait_busy_low();
  endtask

  // Idle line, nothing left outstanding
  task automatic check_drained();
    assert (txd === 1'b1 && busy === 1'b0 && exp_q.size() == 0) else
      abort_run($sformatf("%s: not idle after the line, %0d bytes still expected",
                          test_name, exp_q.size()));
  endtask

  initial begin
    int target;
    reset = 1'b1;
    req   = '0;
    apply_reset();

    test_name = "after_reset";
    assert (txd === 1'b1 && busy === 1'b0) else
      abort_run("after_reset: txd not high or busy not low after reset");
    print_line('0);
    check_drained();

    test_name = "random_values";
    repeat (16) begin
      print_line(value_t'($random(seed)));
      check_drained();
    end

    test_name = "top_nibble_pad";
    print_line('1);
    check_drained();

    // Extra captures while busy must vanish
    test_name = "busy_reject";
    capture_value(value_t'(30'h1234ABCD));
    wait_busy_high();
    repeat (3) begin
      repeat (25) @(posedge clk);
      req.value   <= value_t'($random(seed));
      req.capture <= 1'b1;
      @(posedge clk);
      req.capture <= 1'b0;
    end
    @(negedge clk);
    wait_busy_low();
    check_drained();

    // Second capture held so it lands in the first idle cycle
    test_name = "back_to_back";
    capture_value(value_t'($random(seed)));
    wait_busy_high();
    @(posedge clk);
    req.value   <= value_t'($random(seed));
    req.capture <= 1'b1;
    @(negedge clk);
    wait_busy_low();
    @(posedge clk);
    req.capture <= 1'b0;
    @(negedge clk);
    assert (busy === 1'b1) else
      abort_run("back_to_back: capture in the cycle after busy fell was not taken");
    wait_busy_low();
    check_drained();

    test_name = "reset_mid_line";
    target = rx_count + 3;
    capture_value(value_t'($random(seed)));
    while (rx_count < target) @(negedge clk);
    // Somewhere inside the fourth character
    repeat (30) @(negedge clk);
    apply_reset();
    assert (txd === 1'b1 && busy === 1'b0) else
      abort_run("reset_mid_line: txd not high or busy not low after reset");
    exp_q.delete();
    print_line(value_t'($random(seed)));
    check_drained();

    test_name = "end";
    if (exp_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort_run($sformatf("%0d expected bytes never arrived", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/debug_print_pkg.sv
common/uart_pkg.sv
source/bits_to_hex.sv
source/hex_line_formatter.sv
uart/uart_tx.sv
source/debug_hex_printer.sv
tests/uart_rx_model.sv
tests/tb_debug_hex_printer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug hex printer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_debug_hex_printer -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
